// ==== include/csr_addr.svh ====
`ifndef CSR_ADDR_SVH
`define CSR_ADDR_SVH

//////////////////////////////////////////////////////////////////////
// machine CSR addresses, needs csr_addr_t declared first
//////////////////////////////////////////////////////////////////////

// read-only ID registers
localparam csr_addr_t CSR_MVENDORID = 12'hF11;
localparam csr_addr_t CSR_MARCHID   = 12'hF12;
localparam csr_addr_t CSR_MIMPID    = 12'hF13;
localparam csr_addr_t CSR_MHARTID   = 12'hF14;

// machine trap setup and handling
localparam csr_addr_t CSR_MSTATUS   = 12'h300;
localparam csr_addr_t CSR_MISA      = 12'h301;
localparam csr_addr_t CSR_MIE       = 12'h304;
localparam csr_addr_t CSR_MTVEC     = 12'h305;
localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
localparam csr_addr_t CSR_MEPC      = 12'h341;
localparam csr_addr_t CSR_MCAUSE    = 12'h342;
localparam csr_addr_t CSR_MTVAL     = 12'h343;
localparam csr_addr_t CSR_MIP       = 12'h344;

`endif

// ==== source/priv_pkg.sv ====
`default_nettype none

package priv_pkg;

    typedef logic [31:0] xlen_t;     // data word
    typedef logic [11:0] csr_addr_t; // csr address
    typedef logic [4:0]  cause_t;    // exception / interrupt code

    `include "csr_addr.svh"

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_mode_t;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_cmd_t;

    typedef enum logic [1:0] {
        TRAP_NONE,
        TRAP_EXC,
        TRAP_IRQ,
        TRAP_RET   // mret
    } trap_kind_t;

    typedef struct packed {
        csr_cmd_t  cmd;
        csr_addr_t addr;
        xlen_t     operand;
    } csr_op_t;

    typedef struct packed {
        logic   valid;
        cause_t cause;
        xlen_t  pc;
        xlen_t  tval_info; // faulting address or instruction word
    } trap_req_t;

    ////////////////////////////////////////////////////////////////////
    // cause codes
    ////////////////////////////////////////////////////////////////////
    localparam cause_t EXC_I_MISALIGNED = 5'd0;
    localparam cause_t EXC_ILLEGAL      = 5'd2;
    localparam cause_t EXC_BREAKPOINT   = 5'd3;
    localparam cause_t EXC_L_MISALIGNED = 5'd4;
    localparam cause_t EXC_S_MISALIGNED = 5'd6;
    localparam cause_t EXC_ECALL_U      = 5'd8;
    localparam cause_t EXC_ECALL_M      = 5'd11;
    localparam cause_t IRQ_M_TIMER      = 5'd7;
    localparam cause_t IRQ_M_EXT        = 5'd11;

endpackage

`default_nettype wire

// ==== source/csr_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_alu import priv_pkg::*; (
    input  csr_cmd_t   cmd,
    input  xlen_t      operand,
    input  xlen_t      old_value,
    input  trap_kind_t trap_kind,
    output xlen_t      new_value,
    output logic       wr_en
);

    logic op_zero; // rs1 = x0 style set/clear, read only

    assign op_zero = (operand == '0);

    //////////////////////////////////////////////////////////////////
    // result
    //////////////////////////////////////////////////////////////////
    always_comb begin
        case (cmd)
            CSR_WRITE: new_value = operand;
            CSR_SET:   new_value = old_value | operand;
            CSR_CLEAR: new_value = old_value & ~operand;
            default:   new_value = old_value;
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // write strobe
    //////////////////////////////////////////////////////////////////
    always_comb begin
        wr_en = 1'b0;
        if (trap_kind == TRAP_NONE) begin // any trap or mret kills the write
            case (cmd)
                CSR_WRITE: wr_en = 1'b1;
                CSR_SET,
                CSR_CLEAR: wr_en = !op_zero; // no side effect on zero mask
                default:   wr_en = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/irq_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_arbiter import priv_pkg::*; (
    input  logic   irq_ext,
    input  logic   irq_timer,
    input  xlen_t  mie_bits,
    input  logic   mstatus_mie,
    input  logic   stall,
    output xlen_t  mip_bits,
    output logic   irq_take,
    output cause_t irq_cause
);

    xlen_t pending;
    logic  ext_pend;
    logic  tmr_pend;

    // MEIP at bit 11, MTIP at bit 7
    assign mip_bits = {20'b0, irq_ext, 3'b0, irq_timer, 7'b0};

    assign pending  = mip_bits & mie_bits;
    assign ext_pend = pending[IRQ_M_EXT];
    assign tmr_pend = pending[IRQ_M_TIMER];

    //////////////////////////////////////////////////////////////////
    // external before timer
    //////////////////////////////////////////////////////////////////
    always_comb begin
        irq_take  = 1'b0;
        irq_cause = IRQ_M_TIMER;
        if (mstatus_mie && !stall) begin // global enable and no stall
            if (ext_pend) begin
                irq_take  = 1'b1;
                irq_cause = IRQ_M_EXT;
            end else if (tmr_pend) begin
                irq_take  = 1'b1;
                irq_cause = IRQ_M_TIMER;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl import priv_pkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  trap_req_t  trap_req,
    input  logic       mret,
    input  logic       irq_take,
    input  cause_t     irq_cause,
    input  priv_mode_t mpp,
    output trap_kind_t trap_kind,
    output cause_t     trap_cause,
    output priv_mode_t cur_mode,
    output logic       redirect
);

    priv_mode_t mode_q;
    priv_mode_t mode_d;

    //////////////////////////////////////////////////////////////////
    // exception before mret before interrupt
    //////////////////////////////////////////////////////////////////
    always_comb begin
        trap_kind  = TRAP_NONE;
        trap_cause = '0;
        if (trap_req.valid) begin
            trap_kind  = TRAP_EXC;
            trap_cause = trap_req.cause;
        end else if (mret) begin
            trap_kind  = TRAP_RET;
        end else if (irq_take) begin
            trap_kind  = TRAP_IRQ;
            trap_cause = irq_cause;
        end
    end

    assign redirect = (trap_kind != TRAP_NONE); // front end flush + new pc

    //////////////////////////////////////////////////////////////////
    // privilege mode FSM
    //////////////////////////////////////////////////////////////////
    always_comb begin
        mode_d = mode_q;
        case (trap_kind)
            TRAP_EXC,
            TRAP_IRQ: mode_d = PRIV_M;
            TRAP_RET: mode_d = mpp;     // back to stacked mode
            default:  mode_d = mode_q;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            mode_q <= PRIV_M; // boot in machine mode
        end else begin
            mode_q <= mode_d;
        end
    end

    assign cur_mode = mode_q;

    //////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////

    // only M and U exist even after mret from a stacked MPP
    mode_legal: assert property (
        @(posedge clk) disable iff (!nrst)
        cur_mode inside {PRIV_M, PRIV_U}
    ) else $error("illegal privilege mode %0d", cur_mode);

endmodule

`default_nettype wire

// ==== source/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile import priv_pkg::*; #(
    parameter logic [25:0] EXT_MASK = 26'h0101100  // I, M, U
) (
    input  logic       clk,
    input  logic       nrst,
    input  csr_addr_t  addr,
    input  xlen_t      new_value,
    input  logic       wr_en,
    input  trap_kind_t trap_kind,
    input  cause_t     trap_cause,
    input  xlen_t      trap_pc,
    input  xlen_t      trap_tval_info,
    input  priv_mode_t cur_mode,
    input  xlen_t      mip_bits,
    output xlen_t      rdata,
    output logic       illegal,
    output xlen_t      mie_bits,
    output logic       mstatus_mie,
    output priv_mode_t mpp,
    output xlen_t      mtvec,
    output xlen_t      mepc
);

    // mstatus fields
    logic       st_mie;
    logic       st_mpie;
    priv_mode_t st_mpp;
    // mie fields
    logic       meie;
    logic       mtie;
    // full registers
    xlen_t      mtvec_q;
    xlen_t      mscratch_q;
    xlen_t      mepc_q;
    logic       mcause_irq;
    cause_t     mcause_code;
    xlen_t      mtval_q;

    xlen_t      mstatus_rd;
    logic       known;
    logic       read_only;
    logic       csr_we;
    xlen_t      tval_d;

    assign mstatus_rd = {19'b0, st_mpp, 3'b0, st_mpie, 3'b0, st_mie, 3'b0};
    assign mie_bits   = {20'b0, meie, 3'b0, mtie, 7'b0};

    //////////////////////////////////////////////////////////////////
    // read mux and access check
    //////////////////////////////////////////////////////////////////
    always_comb begin
        rdata     = '0;
        known     = 1'b1;
        read_only = 1'b0;
        case (addr)
            CSR_MISA:      rdata = {2'b01, 4'b0, EXT_MASK}; // MXL = 32
            CSR_MVENDORID,
            CSR_MARCHID,
            CSR_MIMPID,
            CSR_MHARTID:   read_only = 1'b1;
            CSR_MSTATUS:   rdata = mstatus_rd;
            CSR_MIE:       rdata = mie_bits;
            CSR_MTVEC:     rdata = mtvec_q;
            CSR_MSCRATCH:  rdata = mscratch_q;
            CSR_MEPC:      rdata = mepc_q;
            CSR_MCAUSE:    rdata = {mcause_irq, 26'b0, mcause_code};
            CSR_MTVAL:     rdata = mtval_q;
            CSR_MIP: begin
                rdata     = mip_bits; // live line levels
                read_only = 1'b1;
            end
            default:       known = 1'b0;
        endcase
    end

    assign illegal = !known || (read_only && wr_en) || (cur_mode == PRIV_U);
    assign csr_we  = wr_en && !illegal;

    // mtval source by exception kind
    always_comb begin
        case (trap_cause)
            EXC_I_MISALIGNED: tval_d = trap_pc;
            EXC_ILLEGAL,
            EXC_L_MISALIGNED,
            EXC_S_MISALIGNED: tval_d = trap_tval_info;
            default:          tval_d = '0;
        endcase
        if (trap_kind == TRAP_IRQ) tval_d = '0;
    end

    //////////////////////////////////////////////////////////////////
    // update: trap entry, then mret, then csr write
    //////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            st_mie      <= 1'b0;
            st_mpie     <= 1'b0;
            st_mpp      <= PRIV_U;
            meie        <= 1'b0;
            mtie        <= 1'b0;
            mtvec_q     <= '0;
            mscratch_q  <= '0;
            mepc_q      <= '0;
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
            mtval_q     <= '0;
        end else if (trap_kind == TRAP_EXC || trap_kind == TRAP_IRQ) begin
            mepc_q      <= {trap_pc[31:2], 2'b00};
            mcause_irq  <= (trap_kind == TRAP_IRQ);
            mcause_code <= trap_cause;
            mtval_q     <= tval_d;
            st_mpie     <= st_mie;
            st_mie      <= 1'b0;
            st_mpp      <= cur_mode;
        end else if (trap_kind == TRAP_RET) begin
            st_mie      <= st_mpie;
            st_mpie     <= 1'b1;
            st_mpp      <= PRIV_U;
        end else if (csr_we) begin
            case (addr)
                CSR_MSTATUS: begin
                    st_mie  <= new_value[3];
                    st_mpie <= new_value[7];
                    // WARL: only U stays U
                    st_mpp  <= (new_value[12:11] == 2'b00) ? PRIV_U : PRIV_M;
                end
                CSR_MIE: begin
                    meie <= new_value[11];
                    mtie <= new_value[7];
                end
                CSR_MTVEC:    mtvec_q    <= {new_value[31:2], 2'b00}; // direct only
                CSR_MSCRATCH: mscratch_q <= new_value;
                CSR_MEPC:     mepc_q     <= {new_value[31:2], 2'b00};
                CSR_MCAUSE: begin
                    mcause_irq  <= new_value[31];
                    mcause_code <= new_value[4:0];
                end
                CSR_MTVAL:    mtval_q    <= new_value;
                default: ;
            endcase
        end
    end

    assign mstatus_mie = st_mie;
    assign mpp         = st_mpp;
    assign mtvec       = mtvec_q;
    assign mepc        = mepc_q;

    // mret target stays word aligned, whichever path wrote it
    mepc_aligned: assert property (
        @(posedge clk) disable iff (!nrst)
        mepc_q[1:0] == 2'b00
    ) else $error("mepc low bits set: %h", mepc_q);

endmodule

`default_nettype wire

// ==== source/csr_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top import priv_pkg::*; #(
    parameter logic [25:0] EXT_MASK = 26'h0101100  // I, M, U
) (
    input  logic       clk,
    input  logic       nrst,
    input  csr_op_t    csr_op,
    input  logic       stall,
    input  trap_req_t  trap_req,
    input  logic       mret,
    input  logic       irq_ext,
    input  logic       irq_timer,
    output xlen_t      csr_rdata,
    output logic       illegal_csr,
    output logic       redirect,
    output xlen_t      redirect_pc,
    output priv_mode_t cur_mode
);

    trap_kind_t trap_kind;
    cause_t     trap_cause;
    cause_t     irq_cause;
    logic       irq_take;
    xlen_t      new_value;
    logic       wr_en;
    xlen_t      mie_bits;
    xlen_t      mip_bits;
    logic       mstatus_mie;
    priv_mode_t mpp;
    xlen_t      mtvec;
    xlen_t      mepc;

    //////////////////////////////////////////////////////////////////
    // datapath around the trap control
    //////////////////////////////////////////////////////////////////
    csr_alu u_alu (
        .cmd       (csr_op.cmd),
        .operand   (csr_op.operand),
        .old_value (csr_rdata), // old value from the read port
        .trap_kind (trap_kind),
        .new_value (new_value),
        .wr_en     (wr_en)
    );

    irq_arbiter u_irq (
        .irq_ext     (irq_ext),
        .irq_timer   (irq_timer),
        .mie_bits    (mie_bits),
        .mstatus_mie (mstatus_mie),
        .stall       (stall),
        .mip_bits    (mip_bits),
        .irq_take    (irq_take),
        .irq_cause   (irq_cause)
    );

    trap_ctrl u_ctrl (
        .clk        (clk),
        .nrst       (nrst),
        .trap_req   (trap_req),
        .mret       (mret),
        .irq_take   (irq_take),
        .irq_cause  (irq_cause),
        .mpp        (mpp),
        .trap_kind  (trap_kind),
        .trap_cause (trap_cause),
        .cur_mode   (cur_mode),
        .redirect   (redirect)
    );

    csr_regfile #(
        .EXT_MASK (EXT_MASK)
    ) u_regs (
        .clk            (clk),
        .nrst           (nrst),
        .addr           (csr_op.addr),
        .new_value      (new_value),
        .wr_en          (wr_en),
        .trap_kind      (trap_kind),
        .trap_cause     (trap_cause),
        .trap_pc        (trap_req.pc),
        .trap_tval_info (trap_req.tval_info),
        .cur_mode       (cur_mode),
        .mip_bits       (mip_bits),
        .rdata          (csr_rdata),
        .illegal        (illegal_csr),
        .mie_bits       (mie_bits),
        .mstatus_mie    (mstatus_mie),
        .mpp            (mpp),
        .mtvec          (mtvec),
        .mepc           (mepc)
    );

    // mret goes to mepc, every trap to the vector base
    assign redirect_pc = (trap_kind == TRAP_RET) ? mepc : mtvec;

endmodule

`default_nettype wire

// ==== sim/csr_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_checker import priv_pkg::*; #(
    parameter logic [25:0] EXT_MASK = 26'h0101100
) (
    input  logic            clk,
    input  logic            nrst,
    input  csr_op_t         csr_op,
    input  logic            stall,
    input  trap_req_t       trap_req,
    input  logic            mret,
    input  logic            irq_ext,
    input  logic            irq_timer,
    input  xlen_t           csr_rdata,
    input  logic            illegal_csr,
    input  logic            redirect,
    input  xlen_t           redirect_pc,
    input  priv_mode_t      cur_mode,
    input  logic [8*16-1:0] test_name,
    output int              errors,
    output int              checks
);

    // architectural state of the machine CSRs
    typedef struct packed {
        logic       mie;
        logic       mpie;
        logic [1:0] mpp;
        logic       meie;
        logic       mtie;
        logic [1:0] mode;
        xlen_t      mtvec;
        xlen_t      mscratch;
        xlen_t      mepc;
        xlen_t      mcause;
        xlen_t      mtval;
    } model_t;

    model_t model;

    //////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////
    function automatic model_t reset_model();
        model_t m;
        m      = '0;
        m.mode = 2'b11; // boot in M
        return m;
    endfunction

    function automatic xlen_t read_ref(input model_t m, input csr_addr_t a,
                                       input logic ext, input logic tmr);
        xlen_t v;
        v = '0;
        case (a)
            CSR_MISA:     v = {2'b01, 4'b0000, EXT_MASK};
            CSR_MSTATUS: begin
                v[12:11] = m.mpp;
                v[7]     = m.mpie;
                v[3]     = m.mie;
            end
            CSR_MIE: begin
                v[11] = m.meie;
                v[7]  = m.mtie;
            end
            CSR_MIP: begin
                v[11] = ext;
                v[7]  = tmr;
            end
            CSR_MTVEC:    v = m.mtvec;
            CSR_MSCRATCH: v = m.mscratch;
            CSR_MEPC:     v = m.mepc;
            CSR_MCAUSE:   v = m.mcause;
            CSR_MTVAL:    v = m.mtval;
            default:      v = '0; // IDs and unknown addresses
        endcase
        return v;
    endfunction

    function automatic trap_kind_t kind_ref(input model_t m, input trap_req_t tr,
                                            input logic ret, input logic stl,
                                            input logic ext, input logic tmr);
        logic irq;
        irq = m.mie && !stl && ((ext && m.meie) || (tmr && m.mtie));
        if (tr.valid) return TRAP_EXC;
        if (ret) return TRAP_RET;
        if (irq) return TRAP_IRQ;
        return TRAP_NONE;
    endfunction

    // set/clear with zero mask is a pure read
    function automatic logic writes_csr(input csr_op_t op, input trap_kind_t k);
        if (k != TRAP_NONE) return 1'b0;
        if (op.cmd == CSR_WRITE) return 1'b1;
        return (op.cmd != CSR_NONE) && (op.operand != '0);
    endfunction

    function automatic logic illegal_ref(input model_t m, input csr_op_t op,
                                         input trap_kind_t k);
        logic known;
        logic ro;
        known = 1'b1;
        ro    = 1'b0;
        case (op.addr)
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID, CSR_MIP: ro = 1'b1;
            CSR_MISA, CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
            CSR_MEPC, CSR_MCAUSE, CSR_MTVAL: ro = 1'b0;
            default: known = 1'b0;
        endcase
        return !known || (ro && writes_csr(op, k)) || (m.mode == 2'b00);
    endfunction

    function automatic model_t step_ref(input model_t m, input csr_op_t op,
                                        input trap_req_t tr, input logic ret,
                                        input logic stl, input logic ext, input logic tmr);
        model_t     n;
        trap_kind_t k;
        xlen_t      old;
        xlen_t      v;
        cause_t     c;
        n   = m;
        k   = kind_ref(m, tr, ret, stl, ext, tmr);
        old = read_ref(m, op.addr, ext, tmr);
        if (k == TRAP_EXC || k == TRAP_IRQ) begin
            c = tr.cause;
            if (k == TRAP_IRQ) c = (ext && m.meie) ? IRQ_M_EXT : IRQ_M_TIMER;
            n.mepc   = tr.pc & ~32'h3;
            n.mcause = {(k == TRAP_IRQ), 26'b0, c};
            n.mtval  = '0;
            if (k == TRAP_EXC) begin
                case (c)
                    EXC_I_MISALIGNED: n.mtval = tr.pc;
                    EXC_ILLEGAL, EXC_L_MISALIGNED, EXC_S_MISALIGNED: n.mtval = tr.tval_info;
                    default: n.mtval = '0;
                endcase
            end
            n.mpie = m.mie;
            n.mie  = 1'b0;
            n.mpp  = m.mode;
            n.mode = 2'b11;
        end else if (k == TRAP_RET) begin
            n.mie  = m.mpie;
            n.mpie = 1'b1;
            n.mode = m.mpp;
            n.mpp  = 2'b00;
        end else if (writes_csr(op, k) && !illegal_ref(m, op, k)) begin
            case (op.cmd)
                CSR_WRITE: v = op.operand;
                CSR_SET:   v = old | op.operand;
                default:   v = old & ~op.operand;
            endcase
            case (op.addr)
                CSR_MSTATUS: begin
                    n.mie  = v[3];
                    n.mpie = v[7];
                    n.mpp  = (v[12:11] == 2'b00) ? 2'b00 : 2'b11; // only M or U
                end
                CSR_MIE: begin
                    n.meie = v[11];
                    n.mtie = v[7];
                end
                CSR_MTVEC:    n.mtvec    = v & ~32'h3;
                CSR_MSCRATCH: n.mscratch = v;
                CSR_MEPC:     n.mepc     = v & ~32'h3;
                CSR_MCAUSE:   n.mcause   = {v[31], 26'b0, v[4:0]};
                CSR_MTVAL:    n.mtval    = v;
                default: ;
            endcase
        end
        return n;
    endfunction

    //////////////////////////////////////////////////////////////////
    // compare on the falling edge when outputs are settled
    //////////////////////////////////////////////////////////////////
    task automatic compare_value(input string sig, input xlen_t exp, input xlen_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %0s %0s: expected %h, actual %h", test_name, sig, exp, act);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
    end

    always @(negedge clk) begin
        trap_kind_t k;
        if (!nrst) begin
            model = reset_model();
        end else begin
            k = kind_ref(model, trap_req, mret, stall, irq_ext, irq_timer);
            compare_value("csr_rdata", read_ref(model, csr_op.addr, irq_ext, irq_timer),
                          csr_rdata);
            compare_value("illegal_csr", xlen_t'(illegal_ref(model, csr_op, k)),
                          xlen_t'(illegal_csr));
            compare_value("redirect", xlen_t'(k != TRAP_NONE), xlen_t'(redirect));
            compare_value("redirect_pc", (k == TRAP_RET) ? model.mepc : model.mtvec,
                          redirect_pc);
            compare_value("cur_mode", xlen_t'(model.mode), xlen_t'(cur_mode));
            model = step_ref(model, csr_op, trap_req, mret, stall, irq_ext, irq_timer);
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit import priv_pkg::*; ();

    localparam logic [25:0] EXT_MASK    = 26'h0101100;
    localparam int          RAND_OPS    = 200;
    // reset, id reads, random ops, exceptions, mret, irq, illegal, tail
    localparam int          TEST_CYCLES = 17 + 13 + RAND_OPS + 43 + 10 + 20 + 6 + 3;
    localparam int          WATCHDOG_NS = TEST_CYCLES * 4 + 100;

    logic            clk;
    logic            nrst;
    csr_op_t         csr_op;
    logic            stall;
    trap_req_t       trap_req;
    logic            mret;
    logic            irq_ext;
    logic            irq_timer;
    xlen_t           csr_rdata;
    logic            illegal_csr;
    logic            redirect;
    xlen_t           redirect_pc;
    priv_mode_t      cur_mode;

    logic            stall_lvl; // levels applied at the next drive
    logic            ext_lvl;
    logic            tmr_lvl;
    logic [31:0]     rng;
    logic [8*16-1:0] test_name;
    int              errors;
    int              checks;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    csr_unit_top #(.EXT_MASK(EXT_MASK)) uut (
        .clk(clk), .nrst(nrst), .csr_op(csr_op), .stall(stall), .trap_req(trap_req),
        .mret(mret), .irq_ext(irq_ext), .irq_timer(irq_timer), .csr_rdata(csr_rdata),
        .illegal_csr(illegal_csr), .redirect(redirect), .redirect_pc(redirect_pc),
        .cur_mode(cur_mode)
    );

    csr_checker #(.EXT_MASK(EXT_MASK)) u_check (
        .clk(clk), .nrst(nrst), .csr_op(csr_op), .stall(stall), .trap_req(trap_req),
        .mret(mret), .irq_ext(irq_ext), .irq_timer(irq_timer), .csr_rdata(csr_rdata),
        .illegal_csr(illegal_csr), .redirect(redirect), .redirect_pc(redirect_pc),
        .cur_mode(cur_mode), .test_name(test_name), .errors(errors), .checks(checks)
    );

    //////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic csr_addr_t csr_at(input int i);
        case (i)
            0:  return CSR_MISA;
            1:  return CSR_MVENDORID;
            2:  return CSR_MARCHID;
            3:  return CSR_MIMPID;
            4:  return CSR_MHARTID;
            5:  return CSR_MSTATUS;   // 5..9 are the writable targets
            6:  return CSR_MIE;
            7:  return CSR_MTVEC;
            8:  return CSR_MSCRATCH;
            9:  return CSR_MEPC;
            10: return CSR_MCAUSE;
            11: return CSR_MTVAL;
            default: return CSR_MIP;
        endcase
    endfunction

    function automatic cause_t exc_cause(input int i);
        case (i)
            0: return EXC_I_MISALIGNED;
            1: return EXC_ILLEGAL;
            2: return EXC_BREAKPOINT;
            3: return EXC_L_MISALIGNED;
            4: return EXC_S_MISALIGNED;
            5: return EXC_ECALL_U;
            default: return EXC_ECALL_M;
        endcase
    endfunction

    task automatic drive_cycle(input csr_op_t op, input trap_req_t tr, input logic ret);
        @(posedge clk);
        csr_op    <= op;
        trap_req  <= tr;
        mret      <= ret;
        stall     <= stall_lvl;
        irq_ext   <= ext_lvl;
        irq_timer <= tmr_lvl;
    endtask

    task automatic csr_access(input csr_cmd_t cmd, input csr_addr_t addr, input xlen_t val);
        drive_cycle(csr_op_t'{cmd, addr, val}, '0, 1'b0);
    endtask

    task automatic idle_cycle();
        csr_access(CSR_NONE, CSR_MSTATUS, '0);
    endtask

    // the mtvec write alongside must be dropped
    task automatic raise_trap(input cause_t cause, input xlen_t pc, input xlen_t tval);
        drive_cycle(csr_op_t'{CSR_WRITE, CSR_MTVEC, tval},
                    trap_req_t'{1'b1, cause, pc, tval}, 1'b0);
    endtask

    task automatic issue_mret();
        drive_cycle(csr_op_t'{CSR_NONE, CSR_MSTATUS, 32'h0}, '0, 1'b1);
    endtask

    //////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////
    initial begin
        csr_cmd_t  cmd;
        csr_addr_t addr;
        xlen_t     val;
        xlen_t     pc;
        nrst      = 1'b0;
        csr_op    = '0;
        stall     = 1'b0;
        trap_req  = '0;
        mret      = 1'b0;
        irq_ext   = 1'b0;
        irq_timer = 1'b0;
        stall_lvl = 1'b0;
        ext_lvl   = 1'b0;
        tmr_lvl   = 1'b0;
        rng       = 32'h1a7b3c71;
        test_name = "reset";
        repeat (16) @(posedge clk);
        nrst <= 1'b1;

        for (int i = 0; i < 13; i++) csr_access(CSR_NONE, csr_at(i), '0);

        test_name = "csr_random";
        for (int i = 0; i < RAND_OPS; i++) begin
            rng  = xorshift32(rng);
            cmd  = csr_cmd_t'(rng[1:0]);
            addr = csr_at(5 + int'(rng[10:8]) % 5);
            val  = (rng[31:30] == 2'b00) ? '0 : xorshift32(rng); // zero masks too
            rng  = xorshift32(rng);
            csr_access(cmd, addr, val);
        end

        test_name = "exceptions";
        csr_access(CSR_WRITE, CSR_MTVEC, 32'h0000_1f03);
        for (int i = 0; i < 7; i++) begin
            csr_access(CSR_SET, CSR_MSTATUS, 32'h8);
            rng = xorshift32(rng);
            pc  = rng;
            rng = xorshift32(rng);
            raise_trap(exc_cause(i), pc, rng);
            csr_access(CSR_NONE, CSR_MEPC, '0);
            csr_access(CSR_NONE, CSR_MCAUSE, '0);
            csr_access(CSR_NONE, CSR_MTVAL, '0);
            csr_access(CSR_NONE, CSR_MSTATUS, '0);
        end

        test_name = "mret";
        rng = xorshift32(rng);
        csr_access(CSR_WRITE, CSR_MEPC, rng);
        csr_access(CSR_WRITE, CSR_MSTATUS, 32'h0000_1880); // MPP = M, MPIE = 1
        issue_mret();
        csr_access(CSR_NONE, CSR_MSTATUS, '0);
        csr_access(CSR_CLEAR, CSR_MSTATUS, 32'h0000_1800);
        issue_mret();                                       // drop to U
        csr_access(CSR_WRITE, CSR_MSCRATCH, 32'hdead_beef);
        raise_trap(EXC_ECALL_U, 32'h0000_0400, '0);
        csr_access(CSR_NONE, CSR_MSTATUS, '0);
        csr_access(CSR_NONE, CSR_MSCRATCH, '0);

        test_name = "interrupts";
        csr_access(CSR_WRITE, CSR_MIE, '0);
        ext_lvl = 1'b1;
        tmr_lvl = 1'b1;
        repeat (3) csr_access(CSR_NONE, CSR_MIP, '0);
        csr_access(CSR_WRITE, CSR_MIE, 32'h0000_0880);
        repeat (2) csr_access(CSR_NONE, CSR_MIP, '0);     // global enable still off
        stall_lvl = 1'b1;
        csr_access(CSR_SET, CSR_MSTATUS, 32'h8);
        repeat (3) idle_cycle();
        stall_lvl = 1'b0;
        idle_cycle();                                       // external taken
        csr_access(CSR_NONE, CSR_MCAUSE, '0);
        ext_lvl = 1'b0;
        csr_access(CSR_SET, CSR_MSTATUS, 32'h8);
        idle_cycle();                                       // timer taken
        csr_access(CSR_NONE, CSR_MCAUSE, '0);
        ext_lvl = 1'b1;
        csr_access(CSR_SET, CSR_MSTATUS, 32'h8);
        raise_trap(EXC_BREAKPOINT, 32'h0000_0800, '0);     // beats pending irq
        csr_access(CSR_NONE, CSR_MCAUSE, '0);
        ext_lvl = 1'b0;
        tmr_lvl = 1'b0;
        idle_cycle();

        test_name = "illegal";
        csr_access(CSR_WRITE, CSR_MVENDORID, 32'hffff_ffff);
        csr_access(CSR_WRITE, CSR_MIP, 32'h0000_0880);
        csr_access(CSR_NONE, 12'h7c0, '0);
        csr_access(CSR_SET, 12'h7c0, 32'h1);
        csr_access(CSR_NONE, CSR_MVENDORID, '0);
        idle_cycle();

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // hard stop well past the test length
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout: the test sequence did not finish in %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/priv_pkg.sv
source/csr_alu.sv
source/irq_arbiter.sv
source/trap_ctrl.sv
source/csr_regfile.sv
source/csr_unit_top.sv
sim/csr_checker.sv
sim/tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - include_dirs:
      - include
    files:
      - source/priv_pkg.sv
      - source/csr_alu.sv
      - source/irq_arbiter.sv
      - source/trap_ctrl.sv
      - source/csr_regfile.sv
      - source/csr_unit_top.sv
  - target: simulation
    files:
      - sim/csr_checker.sv
      - sim/tb_csr_unit.sv
